// File: bomber_video.f
hw/video_pkg.sv
hw/vga_timing.sv
hw/background_gen.sv
hw/player_sprite.sv
hw/pixel_mixer.sv
hw/bomber_video.sv
sim/bomber_video_tb.sv

// File: hw/background_gen.sv
`timescale 1ns/1ps
`default_nettype none

module background_gen import video_pkg::*; (
   input  logic               clk,
   input  logic               rst,
   input  logic               frame_start,  // strobe at (0,0)
   input  logic [COORD_W-1:0] spot_x,
   input  logic [CHAN_W-1:0]  bck_r,        // base colour request
   input  logic [CHAN_W-1:0]  bck_g,
   input  logic [CHAN_W-1:0]  bck_b,
   output logic [CHAN_W-1:0]  bg_r,
   output logic [CHAN_W-1:0]  bg_g,
   output logic [CHAN_W-1:0]  bg_b
);

   logic [CHAN_W-1:0] base_r, base_g, base_b;  // colour held for the frame
   logic [CHAN_W-1:0] cur_r, cur_g, cur_b;     // colour for this pixel

   // origin pixel already uses the new frame colour
   assign cur_r = frame_start ? bck_r : base_r;
   assign cur_g = frame_start ? bck_g : base_g;
   assign cur_b = frame_start ? bck_b : base_b;

   always_ff @(posedge clk) begin
      if (rst) begin
         base_r <= '0;
         base_g <= '0;
         base_b <= '0;
      end else if (frame_start) begin
         base_r <= bck_r;           // sampled once per frame
         base_g <= bck_g;
         base_b <= bck_b;
      end
   end

   always_ff @(posedge clk) begin
      bg_r <= cur_r;
      bg_g <= cur_g;
      bg_b <= cur_b + spot_x[COORD_W-1:COORD_W-CHAN_W];  // x/4 gradient mod 256
   end

endmodule

`default_nettype wire

// File: hw/bomber_video.sv
`timescale 1ns/1ps
`default_nettype none

module bomber_video import video_pkg::*; (
   input  logic               clk,
   input  logic               rst,
   input  logic [COORD_W-1:0] player_x,      // sprite corner
   input  logic [COORD_W-1:0] player_y,
   input  logic [7:0]         player_color,  // rgb332
   input  logic [CHAN_W-1:0]  bck_r,         // background base colour
   input  logic [CHAN_W-1:0]  bck_g,
   input  logic [CHAN_W-1:0]  bck_b,
   output logic [CHAN_W-1:0]  vga_r,
   output logic [CHAN_W-1:0]  vga_g,
   output logic [CHAN_W-1:0]  vga_b,
   output logic               vga_hs,
   output logic               vga_vs,
   output logic               vga_blank,
   output logic               sof            // start of frame at output
);

   logic [COORD_W-1:0] spot_x, spot_y;       // raster position
   logic               active, hs, vs;
   logic               frame_start;          // strobe at origin
   logic [CHAN_W-1:0]  bg_r, bg_g, bg_b;
   logic [CHAN_W-1:0]  spr_r, spr_g, spr_b;
   logic               spr_hit;

   vga_timing vga_timing_i (
      .clk(clk), .rst(rst),
      .spot_x(spot_x), .spot_y(spot_y),
      .active(active), .hs(hs), .vs(vs),
      .frame_start(frame_start)
   );

   background_gen background_gen_i (
      .clk(clk), .rst(rst), .frame_start(frame_start),
      .spot_x(spot_x),
      .bck_r(bck_r), .bck_g(bck_g), .bck_b(bck_b),
      .bg_r(bg_r), .bg_g(bg_g), .bg_b(bg_b)
   );

   player_sprite player_sprite_i (
      .clk(clk), .rst(rst), .frame_start(frame_start),
      .spot_x(spot_x), .spot_y(spot_y),
      .player_x(player_x), .player_y(player_y),
      .player_color(player_color),
      .spr_hit(spr_hit),
      .spr_r(spr_r), .spr_g(spr_g), .spr_b(spr_b)
   );

   pixel_mixer pixel_mixer_i (
      .clk(clk), .rst(rst),
      .active(active), .hs(hs), .vs(vs), .frame_start(frame_start),
      .bg_r(bg_r), .bg_g(bg_g), .bg_b(bg_b),
      .spr_r(spr_r), .spr_g(spr_g), .spr_b(spr_b),
      .spr_hit(spr_hit),
      .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
      .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_blank(vga_blank),
      .sof(sof)
   );

endmodule

`default_nettype wire

// File: hw/pixel_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer import video_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              active,       // from timing stage
   input  logic              hs,
   input  logic              vs,
   input  logic              frame_start,
   input  logic [CHAN_W-1:0] bg_r,         // renderer stage outputs
   input  logic [CHAN_W-1:0] bg_g,
   input  logic [CHAN_W-1:0] bg_b,
   input  logic [CHAN_W-1:0] spr_r,
   input  logic [CHAN_W-1:0] spr_g,
   input  logic [CHAN_W-1:0] spr_b,
   input  logic              spr_hit,
   output logic [CHAN_W-1:0] vga_r,
   output logic [CHAN_W-1:0] vga_g,
   output logic [CHAN_W-1:0] vga_b,
   output logic              vga_hs,
   output logic              vga_vs,
   output logic              vga_blank,    // high while visible
   output logic              sof
);

   logic              active_d, hs_d, vs_d, sof_d;  // aligned with renderers
   logic [CHAN_W-1:0] pix_r, pix_g, pix_b;

   always_comb begin
      if (!active_d) begin
         pix_r = '0;                 // black in blanking
         pix_g = '0;
         pix_b = '0;
      end else if (spr_hit) begin
         pix_r = spr_r;              // sprite wins
         pix_g = spr_g;
         pix_b = spr_b;
      end else begin
         pix_r = bg_r;
         pix_g = bg_g;
         pix_b = bg_b;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         active_d <= 1'b0;
         hs_d <= 1'b1;
         vs_d <= 1'b1;
         sof_d <= 1'b0;
         vga_r <= '0;
         vga_g <= '0;
         vga_b <= '0;
         vga_hs <= 1'b1;
         vga_vs <= 1'b1;
         vga_blank <= 1'b0;
         sof <= 1'b0;
      end else begin
         active_d <= active;         // match renderer latency
         hs_d <= hs;
         vs_d <= vs;
         sof_d <= frame_start;
         vga_r <= pix_r;
         vga_g <= pix_g;
         vga_b <= pix_b;
         vga_hs <= hs_d;
         vga_vs <= vs_d;
         vga_blank <= active_d;
         sof <= sof_d;
      end
   end

endmodule

`default_nettype wire

// File: hw/player_sprite.sv
`timescale 1ns/1ps
`default_nettype none

module player_sprite import video_pkg::*; (
   input  logic               clk,
   input  logic               rst,
   input  logic               frame_start,   // strobe at (0,0)
   input  logic [COORD_W-1:0] spot_x,
   input  logic [COORD_W-1:0] spot_y,
   input  logic [COORD_W-1:0] player_x,      // sprite top left corner
   input  logic [COORD_W-1:0] player_y,
   input  logic [7:0]         player_color,  // rgb332
   output logic               spr_hit,       // opaque sprite pixel
   output logic [CHAN_W-1:0]  spr_r,
   output logic [CHAN_W-1:0]  spr_g,
   output logic [CHAN_W-1:0]  spr_b
);

   logic [COORD_W-1:0] pos_x, pos_y;     // corner held for the frame
   logic [7:0]         color;            // colour held for the frame
   logic [COORD_W-1:0] cur_x, cur_y;
   logic [7:0]         cur_color;
   logic [COORD_W-1:0] dx, dy;           // offset from corner
   logic               in_box;
   logic               hit;
   logic [2:0]         red3, grn3;
   logic [1:0]         blu2;

   // bypass so the origin pixel sees this frame's values
   assign cur_x = frame_start ? player_x : pos_x;
   assign cur_y = frame_start ? player_y : pos_y;
   assign cur_color = frame_start ? player_color : color;

   assign dx = spot_x - cur_x;           // left of corner wraps to large
   assign dy = spot_y - cur_y;
   assign in_box = (dx < COORD_W'(SPRITE_SIZE)) && (dy < COORD_W'(SPRITE_SIZE));
   // checker of four squares
   assign hit = in_box &&
                (dx[$clog2(SPRITE_SIZE)-1] == dy[$clog2(SPRITE_SIZE)-1]);

   assign red3 = cur_color[7:5];
   assign grn3 = cur_color[4:2];
   assign blu2 = cur_color[1:0];

   always_ff @(posedge clk) begin
      if (rst) begin
         pos_x <= '0;
         pos_y <= '0;
         color <= '0;
      end else if (frame_start) begin
         pos_x <= player_x;              // sampled once per frame
         pos_y <= player_y;
         color <= player_color;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         spr_hit <= 1'b0;
      end else begin
         spr_hit <= hit;
      end
   end

   always_ff @(posedge clk) begin
      spr_r <= {red3, red3, red3[2:1]};  // bit replication to 8 bits
      spr_g <= {grn3, grn3, grn3[2:1]};
      spr_b <= {blu2, blu2, blu2, blu2};
   end

endmodule

`default_nettype wire

// File: hw/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing import video_pkg::*; (
   input  logic               clk,
   input  logic               rst,
   output logic [COORD_W-1:0] spot_x,       // column of current pixel
   output logic [COORD_W-1:0] spot_y,       // line of current pixel
   output logic               active,       // inside visible area
   output logic               hs,           // horizontal sync active low
   output logic               vs,           // vertical sync active low
   output logic               frame_start   // one cycle at (0,0)
);

   logic [COORD_W-1:0] next_x;    // column after this cycle
   logic [COORD_W-1:0] next_y;    // line after this cycle
   logic               line_end;  // last pixel of the line
   logic               frame_end; // last line of the frame

   assign line_end = (spot_x == COORD_W'(H_TOTAL - 1));
   assign frame_end = (spot_y == COORD_W'(V_TOTAL - 1));
   assign next_x = line_end ? '0 : spot_x + 1'b1;  // wraps at H_TOTAL

   always_comb begin
      next_y = spot_y;                    // hold within the line
      if (line_end) begin
         if (frame_end) begin
            next_y = '0;                  // wrap at V_TOTAL
         end else begin
            next_y = spot_y + 1'b1;
         end
      end
   end

   // counters and decodes share one register stage
   always_ff @(posedge clk) begin
      if (rst) begin
         spot_x <= COORD_W'(H_TOTAL - 1);  // so first step lands on (0,0)
         spot_y <= COORD_W'(V_TOTAL - 1);
         active <= 1'b0;
         hs <= 1'b1;                       // sync idle high
         vs <= 1'b1;
         frame_start <= 1'b0;
      end else begin
         spot_x <= next_x;
         spot_y <= next_y;
         active <= (next_x < COORD_W'(H_ACTIVE)) &&
                   (next_y < COORD_W'(V_ACTIVE));
         hs <= !((next_x >= COORD_W'(H_ACTIVE + H_FRONT)) &&
                 (next_x < COORD_W'(H_ACTIVE + H_FRONT + H_SYNC)));
         vs <= !((next_y >= COORD_W'(V_ACTIVE + V_FRONT)) &&
                 (next_y < COORD_W'(V_ACTIVE + V_FRONT + V_SYNC)));
         frame_start <= (next_x == '0) && (next_y == '0);  // strobe at origin
      end
   end

endmodule

`default_nettype wire

// File: hw/video_pkg.sv
`default_nettype none

package video_pkg;

   localparam int COORD_W = 10;    // raster coordinate bits
   localparam int CHAN_W = 8;      // bits per colour channel

   // horizontal timing in pixels
   localparam int H_ACTIVE = 640;  // visible pixels
   localparam int H_FRONT = 16;    // front porch
   localparam int H_SYNC = 96;     // sync pulse width
   localparam int H_BACK = 48;     // back porch

   // vertical timing in lines
   localparam int V_ACTIVE = 480;  // visible lines
   localparam int V_FRONT = 10;    // front porch
   localparam int V_SYNC = 2;      // sync pulse width
   localparam int V_BACK = 33;     // back porch

   localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 800 per line
   localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 525 per frame

   localparam int SPRITE_SIZE = 16;  // sprite edge in pixels
   localparam int PIPE_DEPTH = 2;    // raster position to output pixel

endpackage

`default_nettype wire

// File: sim/bomber_video_patterns.txt
// frame: 1 player_x player_y player_color bck_r bck_g bck_b, all hex, applies to the next frame
// probe: 2 x y r g b, raster order within the frame above; a lone 0 ends the file
1 064 032 e0 10 20 30
2 000 000 10 20 30
2 27f 000 10 20 cf
2 2bc 00a 00 00 00
2 064 032 ff 00 00
2 06c 032 10 20 4b
2 06c 03a ff 00 00
2 074 041 10 20 4d
2 140 1df 10 20 80
1 258 0c8 1c 80 00 f0
2 000 000 80 00 f0
2 064 032 80 00 09
2 03c 064 80 00 ff
2 040 064 80 00 00
2 258 0c8 00 ff 00
2 260 0cf 80 00 88
1 278 1d8 a9 00 40 00
2 27b 1d7 00 40 9e
2 278 1d8 b6 49 55
2 27f 1df b6 49 55
2 278 1e0 00 00 00
1 000 000 49 55 aa ff
2 000 000 49 49 55
2 008 000 55 aa 01
2 010 000 55 aa 03
2 000 008 55 aa ff
2 008 008 49 49 55
2 27f 1df 55 aa 9e
0

// File: sim/bomber_video_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bomber_video_tb import video_pkg::*; ();

   logic               clk;
   logic               rst;
   logic [COORD_W-1:0] player_x, player_y;
   logic [7:0]         player_color;
   logic [CHAN_W-1:0]  bck_r, bck_g, bck_b;
   logic [CHAN_W-1:0]  vga_r, vga_g, vga_b;
   logic               vga_hs, vga_vs, vga_blank, sof;

   logic [15:0]        pat_mem [0:255];     // raw words of the pattern file
   logic [COORD_W-1:0] fr_px [0:15], fr_py [0:15];
   logic [7:0]         fr_col [0:15], fr_r [0:15], fr_g [0:15], fr_b [0:15];
   int                 pr_frame [0:63], pr_x [0:63], pr_y [0:63];
   logic [7:0]         pr_r [0:63], pr_g [0:63], pr_b [0:63];  // expected colour
   int                 nframes, nprobes, errors;
   int                 hc, vc, frame_no, probe_idx;  // raster model at the output
   logic               loaded;

   bomber_video bomber_video_i (
      .clk(clk), .rst(rst),
      .player_x(player_x), .player_y(player_y), .player_color(player_color),
      .bck_r(bck_r), .bck_g(bck_g), .bck_b(bck_b),
      .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
      .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_blank(vga_blank), .sof(sof)
   );

   always #4 clk = ~clk;   // 8 ns pixel clock

   task automatic load_patterns();
      int  idx;
      int  k;
      bit  done;
      idx = 0;
      done = 1'b0;
      nframes = 0;
      nprobes = 0;
      for (k = 0; k < 256; k++) begin
         pat_mem[k] = '0;               // unread words end the list
      end
      $readmemh("sim/bomber_video_patterns.txt", pat_mem);
      while (!done && idx < 249) begin
         case (pat_mem[idx])
            16'h1: begin
               fr_px[nframes] = pat_mem[idx+1][COORD_W-1:0];
               fr_py[nframes] = pat_mem[idx+2][COORD_W-1:0];
               fr_col[nframes] = pat_mem[idx+3][7:0];
               fr_r[nframes] = pat_mem[idx+4][7:0];
               fr_g[nframes] = pat_mem[idx+5][7:0];
               fr_b[nframes] = pat_mem[idx+6][7:0];
               nframes++;
               idx += 7;
            end
            16'h2: begin
               pr_frame[nprobes] = nframes - 1;  // belongs to last frame record
               pr_x[nprobes] = pat_mem[idx+1];
               pr_y[nprobes] = pat_mem[idx+2];
               pr_r[nprobes] = pat_mem[idx+3][7:0];
               pr_g[nprobes] = pat_mem[idx+4][7:0];
               pr_b[nprobes] = pat_mem[idx+5][7:0];
               nprobes++;
               idx += 6;
            end
            16'h0: done = 1'b1;
            default: begin
               $display("pattern file has unknown record kind %0h at word %0d",
                        pat_mem[idx], idx);
               errors++;
               done = 1'b1;
            end
         endcase
      end
   endtask

   task automatic apply_frame(input int k);
      player_x = fr_px[k];
      player_y = fr_py[k];
      player_color = fr_col[k];
      bck_r = fr_r[k];
      bck_g = fr_g[k];
      bck_b = fr_b[k];
   endtask

   task automatic expect_val(input string name, input logic [7:0] exp,
                             input logic [7:0] act);
      if (act !== exp) begin
         errors++;
         $display("ERR %0t %s expected %0h got %0h", $time, name, exp, act);
      end
   endtask

   task automatic check_idle();
      expect_val("sof", 1'b0, sof);
      expect_val("vga_blank", 1'b0, vga_blank);
      expect_val("vga_hs", 1'b1, vga_hs);   // sync idles high
      expect_val("vga_vs", 1'b1, vga_vs);
      expect_val("vga_r", 8'h00, vga_r);
      expect_val("vga_g", 8'h00, vga_g);
      expect_val("vga_b", 8'h00, vga_b);
   endtask

   task automatic check_raster();
      logic vis;
      logic hs_exp;
      logic vs_exp;
      vis = (hc < H_ACTIVE) && (vc < V_ACTIVE);
      hs_exp = !((hc >= H_ACTIVE + H_FRONT) && (hc < H_ACTIVE + H_FRONT + H_SYNC));
      vs_exp = !((vc >= V_ACTIVE + V_FRONT) && (vc < V_ACTIVE + V_FRONT + V_SYNC));
      expect_val("sof", (hc == 0) && (vc == 0), sof);  // once per frame at origin
      expect_val("vga_hs", hs_exp, vga_hs);
      expect_val("vga_vs", vs_exp, vga_vs);
      expect_val("vga_blank", vis, vga_blank);
      if (!vis) begin
         expect_val("vga_r", 8'h00, vga_r);   // black outside visible area
         expect_val("vga_g", 8'h00, vga_g);
         expect_val("vga_b", 8'h00, vga_b);
      end
      if (probe_idx < nprobes && pr_frame[probe_idx] == frame_no &&
          pr_x[probe_idx] == hc && pr_y[probe_idx] == vc) begin
         expect_val("vga_r", pr_r[probe_idx], vga_r);
         expect_val("vga_g", pr_g[probe_idx], vga_g);
         expect_val("vga_b", pr_b[probe_idx], vga_b);
         probe_idx++;
      end
   endtask

   task automatic finish_run();
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   endtask

   initial begin
      int i;
      int drive_idx;
      clk = 1'b0;
      rst = 1'b1;
      player_x = '0;
      player_y = '0;
      player_color = '0;
      bck_r = '0;
      bck_g = '0;
      bck_b = '0;
      errors = 0;
      probe_idx = 0;
      loaded = 1'b0;
      load_patterns();
      loaded = 1'b1;
      if (nframes > 0) begin
         apply_frame(0);                 // first frame after reset
      end else begin
         $display("pattern file holds no frame record");
         errors++;
      end
      for (i = 0; i < 5; i++) begin
         @(posedge clk);
         #1;
         if (i == 4) begin
            rst = 1'b0;                  // after 5 reset cycles
         end
         @(negedge clk);
         check_idle();
      end
      @(posedge clk);
      @(negedge clk);
      check_idle();                      // first cycle out of reset
      i = 0;
      while (sof !== 1'b1 && i < 2 * PIPE_DEPTH + 4) begin
         @(posedge clk);
         @(negedge clk);
         i++;
      end
      if (sof !== 1'b1) begin
         $display("sof never rose after reset was released");
         errors++;
      end else begin
         if (i != PIPE_DEPTH) begin
            $display("ERR %0t sof latency expected %0d got %0d", $time, PIPE_DEPTH, i);
            errors++;
         end
         hc = 0;
         vc = 0;
         frame_no = 0;
         while (frame_no < nframes) begin
            check_raster();
            drive_idx = (hc == 0 && vc == 0) ? frame_no + 1 : 0;  // next frame values
            if (hc == H_TOTAL - 1) begin
               hc = 0;
               if (vc == V_TOTAL - 1) begin
                  vc = 0;
                  frame_no++;
               end else begin
                  vc++;
               end
            end else begin
               hc++;
            end
            @(posedge clk);
            #1;
            if (drive_idx > 0 && drive_idx < nframes) begin
               apply_frame(drive_idx);   // takes effect from next sof
            end
            @(negedge clk);
         end
         if (probe_idx < nprobes) begin
            $display("%0d probe records were never reached", nprobes - probe_idx);
            errors++;
         end
      end
      finish_run();
   end

   initial begin
      wait (loaded === 1'b1);
      #((nframes + 2) * H_TOTAL * V_TOTAL * 8.0);  // frames plus margin
      $display("watchdog expired before the last frame was checked");
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire
